/* hdl/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// integer datapath width
`define XLEN 64

// tag widths
`define ROB_IDX_W 6
`define PRF_IDX_W 7
`define FTQ_IDX_W 4

// bytes covered by one fetch block
`define FTB_PREDICT_WIDTH 32

// byte offset of an instruction inside its fetch block
`define FTQ_OFFSET_W ($clog2(`FTB_PREDICT_WIDTH))

// writeback queue depth
`define WBQ_DEPTH 8

// stall-frozen stages ahead of the queues, sets the almost-full threshold
`define PIPE_STAGES 3

`endif

/* hdl/exu_pkg.sv */
`default_nettype none

`include "exu_config.svh"

package exu_pkg;

    // 24 executable ops, illegal encodings fall back to nop
    typedef enum logic [4:0] {
        uop_nop,
        uop_lui,
        uop_add,
        uop_sub,
        uop_addw,
        uop_subw,
        uop_sll,
        uop_srl,
        uop_sra,
        uop_sllw,
        uop_srlw,
        uop_sraw,
        uop_xor,
        uop_or,
        uop_and,
        uop_slt,
        uop_sltu,
        uop_jal,
        uop_jalr,
        uop_beq,
        uop_bne,
        uop_blt,
        uop_bge,
        uop_bltu,
        uop_bgeu
    } micop_t;

    typedef enum logic [2:0] {
        br_cond,
        br_direct,
        br_indirect,
        br_call,
        br_ret
    } branch_type_t;

    // one dispatched instruction with its operands already read
    typedef struct packed {
        logic [31:0]                 inst;
        logic [`XLEN-1:0]            pc;
        logic [`XLEN-1:0]            pred_npc;
        logic [1:0][`XLEN-1:0]       srcs;
        logic [`ROB_IDX_W-1:0]       rob_idx;
        logic [`FTQ_IDX_W-1:0]       ftq_idx;
        logic [`FTQ_OFFSET_W-1:0]    ftq_offset;
        logic [`PRF_IDX_W-1:0]       prd_idx;
    } disp_info_t;

    // imm20 holds imm[20:1] for jal, imm[12:1] for branches,
    // the I immediate for jalr and the U bits for lui
    typedef struct packed {
        micop_t                      micop;
        logic [1:0][`XLEN-1:0]       srcs;
        logic [`XLEN-1:0]            pc;
        logic [`XLEN-1:0]            npc;
        logic [19:0]                 imm20;
        logic                        use_imm;
        logic                        rd_wen;
        logic [`PRF_IDX_W-1:0]       prd_idx;
        logic [`ROB_IDX_W-1:0]       rob_idx;
        logic [`FTQ_IDX_W-1:0]       ftq_idx;
        logic [`FTQ_OFFSET_W-1:0]    ftq_offset;
    } fu_info_t;

    typedef struct packed {
        logic [`ROB_IDX_W-1:0]       rob_idx;
        logic [`PRF_IDX_W-1:0]       prd_idx;
        logic                        rd_wen;
        logic                        use_imm;
        logic [`XLEN-1:0]            result;
    } comwb_info_t;

    typedef struct packed {
        branch_type_t                branch_type;
        logic [`ROB_IDX_W-1:0]       rob_idx;
        logic [`FTQ_IDX_W-1:0]       ftq_idx;
        logic                        has_mispred;
        logic                        branch_taken;
        logic [`FTQ_OFFSET_W-1:0]    fallthru_offset;
        logic [`XLEN-1:0]            target_pc;
        logic [`XLEN-1:0]            branch_npc;
    } branchwb_info_t;

endpackage

`default_nettype wire

/* hdl/uop_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module uop_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_stall,
    input  logic                 i_disp_vld,
    input  exu_pkg::disp_info_t  i_disp_info,
    output logic                 o_vld,
    output exu_pkg::fu_info_t    o_fu_info
);
    import exu_pkg::*;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_32  = 7'b0111011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    logic [31:0]      inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             alt;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [19:0]      imm_b;
    logic [19:0]      imm_j;
    micop_t           micop;
    logic             use_imm;
    logic [`XLEN-1:0] imm_alu;
    logic [19:0]      imm20;
    logic             is_cond;
    logic [`XLEN-1:0] src1;
    fu_info_t         fu_info;

    assign inst   = i_disp_info.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    // funct7 bit 5 picks sub and the arithmetic shifts
    assign alt    = inst[30];
    assign rd     = inst[11:7];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'd0};
    // branch and jump offsets kept in halfword units
    assign imm_b = {{8{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8]};
    assign imm_j = {inst[31], inst[19:12], inst[20], inst[30:21]};

    always_comb begin
        micop   = uop_nop;
        use_imm = 1'b0;
        imm_alu = imm_i;
        imm20   = '0;
        case (opcode)
            opc_lui: begin
                micop   = uop_lui;
                use_imm = 1'b1;
                imm_alu = imm_u;
                imm20   = inst[31:12];
            end
            opc_op_imm, opc_op: begin
                use_imm = (opcode == opc_op_imm);
                imm20   = imm_i[19:0];
                case (funct3)
                    3'b000:  micop = (alt && opcode == opc_op) ? uop_sub : uop_add;
                    3'b001:  micop = uop_sll;
                    3'b010:  micop = uop_slt;
                    3'b011:  micop = uop_sltu;
                    3'b100:  micop = uop_xor;
                    3'b101:  micop = alt ? uop_sra : uop_srl;
                    3'b110:  micop = uop_or;
                    default: micop = uop_and;
                endcase
            end
            opc_imm_32, opc_op_32: begin
                use_imm = (opcode == opc_imm_32);
                imm20   = imm_i[19:0];
                case (funct3)
                    3'b000:  micop = (alt && opcode == opc_op_32) ? uop_subw : uop_addw;
                    3'b001:  micop = uop_sllw;
                    3'b101:  micop = alt ? uop_sraw : uop_srlw;
                    default: micop = uop_nop;
                endcase
            end
            opc_jal: begin
                micop = uop_jal;
                imm20 = imm_j;
            end
            opc_jalr: begin
                micop = uop_jalr;
                imm20 = imm_i[19:0];
            end
            opc_branch: begin
                imm20 = imm_b;
                case (funct3)
                    3'b000:  micop = uop_beq;
                    3'b001:  micop = uop_bne;
                    3'b100:  micop = uop_blt;
                    3'b101:  micop = uop_bge;
                    3'b110:  micop = uop_bltu;
                    3'b111:  micop = uop_bgeu;
                    default: micop = uop_nop;
                endcase
            end
            default: micop = uop_nop;
        endcase
    end

    assign is_cond = (opcode == opc_branch);
    assign src1    = use_imm ? imm_alu : i_disp_info.srcs[1];

    assign fu_info = '{
        micop:      micop,
        srcs:       {src1, i_disp_info.srcs[0]},
        pc:         i_disp_info.pc,
        npc:        i_disp_info.pred_npc,
        imm20:      imm20,
        use_imm:    use_imm,
        rd_wen:     (rd != 5'd0) && !is_cond,
        prd_idx:    i_disp_info.prd_idx,
        rob_idx:    i_disp_info.rob_idx,
        ftq_idx:    i_disp_info.ftq_idx,
        ftq_offset: i_disp_info.ftq_offset
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            o_vld <= 1'b0;
        end else if (!i_stall) begin
            o_vld <= i_disp_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_fu_info <= fu_info;
        end
    end

endmodule

`default_nettype wire

/* hdl/alu_bru.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module alu_bru (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_stall,
    input  logic                     i_vld,
    input  exu_pkg::fu_info_t        i_fu_info,
    output logic                     o_willwrite_vld,
    output logic [`PRF_IDX_W-1:0]    o_willwrite_idx,
    output logic [`XLEN-1:0]         o_willwrite_data,
    output logic                     o_fu_finished,
    output exu_pkg::comwb_info_t     o_comwb_info,
    output logic                     o_branchwb_vld,
    output exu_pkg::branchwb_info_t  o_branchwb_info
);
    import exu_pkg::*;

    logic                      saved_vld;
    fu_info_t                  saved;
    logic [`XLEN-1:0]          src0;
    logic [`XLEN-1:0]          src1;
    logic [5:0]                shamt;
    logic [`XLEN-1:0]          add_res;
    logic [`XLEN-1:0]          sub_res;
    logic [31:0]               sllw_res;
    logic [31:0]               srlw_res;
    logic [31:0]               sraw_res;
    logic                      lt_s;
    logic                      lt_u;
    logic                      eq;
    logic [`XLEN-1:0]          fallthru;
    logic [`XLEN-1:0]          imm_ext;
    logic [`XLEN-1:0]          br_target;
    logic [`XLEN-1:0]          jalr_sum;
    logic [`XLEN-1:0]          target;
    logic [`XLEN-1:0]          npc;
    logic [`XLEN-1:0]          calc_data;
    logic                      is_branch;
    logic                      taken;
    logic                      mispred;
    branch_type_t              branch_type;
    logic [`FTQ_OFFSET_W:0]    fallthru_sum;
    logic [`FTQ_OFFSET_W-1:0]  fallthru_offset;
    logic                      fu_finished;
    logic                      branchwb_vld;

    // stage 1 holds the micro-op
    always_ff @(posedge clk) begin
        if (rst) begin
            saved_vld <= 1'b0;
        end else if (!i_stall) begin
            saved_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            saved <= i_fu_info;
        end
    end

    assign src0  = saved.srcs[0];
    assign src1  = saved.srcs[1];
    assign shamt = src1[5:0];

    assign add_res = src0 + src1;
    assign sub_res = src0 - src1;
    // word forms shift only the low half by 5 bits
    assign sllw_res = src0[31:0] << shamt[4:0];
    assign srlw_res = src0[31:0] >> shamt[4:0];
    assign sraw_res = $signed(src0[31:0]) >>> shamt[4:0];

    assign lt_s = $signed(src0) < $signed(src1);
    assign lt_u = src0 < src1;
    assign eq   = (src0 == src1);

    assign fallthru  = saved.pc + `XLEN'(4);
    assign imm_ext   = {{(`XLEN-20){saved.imm20[19]}}, saved.imm20};
    assign br_target = saved.pc + {imm_ext[`XLEN-2:0], 1'b0};
    assign jalr_sum  = src0 + imm_ext;

    always_comb begin
        calc_data = '0;
        taken     = 1'b0;
        is_branch = 1'b1;
        target    = br_target;
        case (saved.micop)
            uop_lui:  calc_data = src1;
            uop_add:  calc_data = add_res;
            uop_sub:  calc_data = sub_res;
            uop_addw: calc_data = {{32{add_res[31]}}, add_res[31:0]};
            uop_subw: calc_data = {{32{sub_res[31]}}, sub_res[31:0]};
            uop_sll:  calc_data = src0 << shamt;
            uop_srl:  calc_data = src0 >> shamt;
            uop_sra:  calc_data = $signed(src0) >>> shamt;
            uop_sllw: calc_data = {{32{sllw_res[31]}}, sllw_res};
            uop_srlw: calc_data = {{32{srlw_res[31]}}, srlw_res};
            uop_sraw: calc_data = {{32{sraw_res[31]}}, sraw_res};
            uop_xor:  calc_data = src0 ^ src1;
            uop_or:   calc_data = src0 | src1;
            uop_and:  calc_data = src0 & src1;
            uop_slt:  calc_data = {{(`XLEN-1){1'b0}}, lt_s};
            uop_sltu: calc_data = {{(`XLEN-1){1'b0}}, lt_u};
            uop_jal: begin
                // link address
                calc_data = fallthru;
                taken     = 1'b1;
            end
            uop_jalr: begin
                calc_data = fallthru;
                taken     = 1'b1;
                target    = {jalr_sum[`XLEN-1:1], 1'b0};
            end
            uop_beq:  taken = eq;
            uop_bne:  taken = !eq;
            uop_blt:  taken = lt_s;
            uop_bge:  taken = !lt_s;
            uop_bltu: taken = lt_u;
            uop_bgeu: taken = !lt_u;
            default:  is_branch = 1'b0;
        endcase
        if (saved.micop inside {[uop_nop:uop_sltu]}) begin
            is_branch = 1'b0;
        end
    end

    assign npc     = taken ? target : fallthru;
    assign mispred = (npc != saved.npc);

    always_comb begin
        if (saved.micop == uop_jalr) begin
            if (saved.prd_idx == `PRF_IDX_W'(1)) begin
                branch_type = br_call;
            end else if (saved.prd_idx == '0) begin
                branch_type = br_ret;
            end else begin
                branch_type = br_indirect;
            end
        end else if (saved.micop == uop_jal) begin
            branch_type = br_direct;
        end else begin
            branch_type = br_cond;
        end
    end

    // next slot in the fetch block, clamped to its last byte
    assign fallthru_sum    = {1'b0, saved.ftq_offset} + 3'd4;
    assign fallthru_offset = (fallthru_sum >= `FTB_PREDICT_WIDTH)
                           ? `FTQ_OFFSET_W'(`FTB_PREDICT_WIDTH - 1)
                           : fallthru_sum[`FTQ_OFFSET_W-1:0];

    // stage 2 registers both writeback records
    always_ff @(posedge clk) begin
        if (rst) begin
            fu_finished  <= 1'b0;
            branchwb_vld <= 1'b0;
        end else if (!i_stall) begin
            fu_finished  <= saved_vld;
            branchwb_vld <= saved_vld && is_branch && mispred;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_comwb_info <= '{
                rob_idx: saved.rob_idx,
                prd_idx: saved.prd_idx,
                rd_wen:  saved.rd_wen,
                use_imm: saved.use_imm,
                result:  calc_data
            };
            o_branchwb_info <= '{
                branch_type:     branch_type,
                rob_idx:         saved.rob_idx,
                ftq_idx:         saved.ftq_idx,
                has_mispred:     mispred,
                branch_taken:    taken,
                fallthru_offset: fallthru_offset,
                target_pc:       target,
                branch_npc:      npc
            };
        end
    end

    // bypass one cycle ahead of the registered result
    assign o_willwrite_vld  = saved_vld && saved.rd_wen;
    assign o_willwrite_idx  = saved.prd_idx;
    assign o_willwrite_data = calc_data;

    // a frozen record is handed over once the stall clears
    assign o_fu_finished  = fu_finished && !i_stall;
    assign o_branchwb_vld = branchwb_vld && !i_stall;

endmodule

`default_nettype wire

/* hdl/wb_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module wb_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `WBQ_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_push,
    input  payload_t i_push_data,
    output logic     o_vld,
    input  logic     i_rdy,
    output payload_t o_data,
    output logic     o_almost_full
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic             do_push;
    logic             do_pop;

    // keep room for everything still in the frozen stages
    assign free_cnt      = CNT_W'(DEPTH) - count;
    assign o_almost_full = (free_cnt <= CNT_W'(`PIPE_STAGES));

    assign do_push = i_push && !o_almost_full;
    assign do_pop  = o_vld && i_rdy;
    assign o_vld   = (count != '0);
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_disp_vld,
    output logic                     o_disp_rdy,
    input  exu_pkg::disp_info_t      i_disp_info,
    output logic                     o_willwrite_vld,
    output logic [`PRF_IDX_W-1:0]    o_willwrite_idx,
    output logic [`XLEN-1:0]         o_willwrite_data,
    output logic                     o_comwb_vld,
    input  logic                     i_comwb_rdy,
    output exu_pkg::comwb_info_t     o_comwb_info,
    output logic                     o_brwb_vld,
    input  logic                     i_brwb_rdy,
    output exu_pkg::branchwb_info_t  o_brwb_info
);
    import exu_pkg::*;

    logic           stall;
    logic           comq_af;
    logic           brq_af;
    logic           dec_vld;
    fu_info_t       dec_fu_info;
    logic           fu_finished;
    comwb_info_t    comwb_info;
    logic           branchwb_vld;
    branchwb_info_t branchwb_info;

    // either queue near full freezes the whole pipe
    assign stall      = comq_af || brq_af;
    assign o_disp_rdy = !stall;

    uop_decode uop_decode_inst (
        .clk         (clk),
        .rst         (rst),
        .i_stall     (stall),
        .i_disp_vld  (i_disp_vld),
        .i_disp_info (i_disp_info),
        .o_vld       (dec_vld),
        .o_fu_info   (dec_fu_info)
    );

    alu_bru alu_bru_inst (
        .clk              (clk),
        .rst              (rst),
        .i_stall          (stall),
        .i_vld            (dec_vld),
        .i_fu_info        (dec_fu_info),
        .o_willwrite_vld  (o_willwrite_vld),
        .o_willwrite_idx  (o_willwrite_idx),
        .o_willwrite_data (o_willwrite_data),
        .o_fu_finished    (fu_finished),
        .o_comwb_info     (comwb_info),
        .o_branchwb_vld   (branchwb_vld),
        .o_branchwb_info  (branchwb_info)
    );

    wb_queue #(
        .payload_t (comwb_info_t),
        .DEPTH     (`WBQ_DEPTH)
    ) comwb_queue_inst (
        .clk           (clk),
        .rst           (rst),
        .i_push        (fu_finished),
        .i_push_data   (comwb_info),
        .o_vld         (o_comwb_vld),
        .i_rdy         (i_comwb_rdy),
        .o_data        (o_comwb_info),
        .o_almost_full (comq_af)
    );

    wb_queue #(
        .payload_t (branchwb_info_t),
        .DEPTH     (`WBQ_DEPTH)
    ) brwb_queue_inst (
        .clk           (clk),
        .rst           (rst),
        .i_push        (branchwb_vld),
        .i_push_data   (branchwb_info),
        .o_vld         (o_brwb_vld),
        .i_rdy         (i_brwb_rdy),
        .o_data        (o_brwb_info),
        .o_almost_full (brq_af)
    );

endmodule

`default_nettype wire

/* sim/tb_exu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module tb_exu;
    import exu_pkg::*;

    localparam int N_OPS       = 400;
    localparam int WATCHDOG_NS = (N_OPS * 40 + 16) * 8;

    logic                    clk;
    logic                    rst;
    logic                    i_disp_vld;
    logic                    o_disp_rdy;
    disp_info_t              i_disp_info;
    logic                    o_willwrite_vld;
    logic [`PRF_IDX_W-1:0]   o_willwrite_idx;
    logic [`XLEN-1:0]        o_willwrite_data;
    logic                    o_comwb_vld;
    logic                    i_comwb_rdy;
    comwb_info_t             o_comwb_info;
    logic                    o_brwb_vld;
    logic                    i_brwb_rdy;
    branchwb_info_t          o_brwb_info;

    logic [63:0]    stim_state;
    logic [63:0]    rdy_state;
    logic           rand_ready;
    comwb_info_t    exp_com[$];
    comwb_info_t    exp_ww[$];
    branchwb_info_t exp_br[$];

    exu_top exu_top_inst (
        .clk              (clk),
        .rst              (rst),
        .i_disp_vld       (i_disp_vld),
        .o_disp_rdy       (o_disp_rdy),
        .i_disp_info      (i_disp_info),
        .o_willwrite_vld  (o_willwrite_vld),
        .o_willwrite_idx  (o_willwrite_idx),
        .o_willwrite_data (o_willwrite_data),
        .o_comwb_vld      (o_comwb_vld),
        .i_comwb_rdy      (i_comwb_rdy),
        .o_comwb_info     (o_comwb_info),
        .o_brwb_vld       (o_brwb_vld),
        .i_brwb_rdy       (i_brwb_rdy),
        .o_brwb_info      (o_brwb_info)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 7);
        v = v ^ (v << 17);
        return v;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // builds one random op and the records it should produce
    task automatic make_op(output disp_info_t d, output comwb_info_t c,
                           output branchwb_info_t b, output logic br_push);
        logic [63:0]  r;
        int           op;
        logic [4:0]   rd;
        logic         imm_form;
        logic [11:0]  imm12;
        logic [63:0]  s0;
        logic [63:0]  s1;
        logic [63:0]  opb;
        logic [63:0]  res;
        logic [63:0]  pc;
        logic [63:0]  tgt;
        logic [63:0]  npc;
        logic [63:0]  pred;
        logic [2:0]   f3;
        logic         alt;
        logic         word;
        logic [6:0]   opc;
        logic [31:0]  inst;
        logic         taken;
        logic [5:0]   sh;
        logic [6:0]   prd;
        logic [20:0]  imm21;
        logic [12:0]  imm13;
        int           fto;
        branch_type_t bt;
        stim_state = xorshift(stim_state);
        op = int'(stim_state % 24);
        stim_state = xorshift(stim_state);
        r = stim_state;
        rd = r[4:0];
        imm_form = r[5];
        imm12 = r[17:6];
        stim_state = xorshift(stim_state);
        s0 = stim_state;
        stim_state = xorshift(stim_state);
        s1 = r[18] ? s0 : stim_state;
        stim_state = xorshift(stim_state);
        pc = {stim_state[63:2], 2'b00};
        // prd 0 and 1 are frequent so jalr covers ret and call
        prd = (r[35:34] == 2'b00) ? {6'd0, r[36]} : r[42:36];
        taken = 1'b0;
        tgt = '0;
        res = '0;
        alt = 1'b0;
        word = 1'b0;
        f3 = 3'd0;
        if (op == 0) begin
            imm_form = 1'b1;
            inst = {r[63:44], rd, 7'b0110111};
            res = {{32{r[63]}}, r[63:44], 12'd0};
        end else if (op <= 15) begin
            if (op == 2 || op == 4) begin
                imm_form = 1'b0;
            end
            case (op)
                2, 4, 7, 10: alt = 1'b1;
                default:     alt = 1'b0;
            endcase
            word = (op == 3 || op == 4 || op == 8 || op == 9 || op == 10);
            case (op)
                5, 8:        f3 = 3'd1;
                6, 7, 9, 10: f3 = 3'd5;
                11:          f3 = 3'd4;
                12:          f3 = 3'd6;
                13:          f3 = 3'd7;
                14:          f3 = 3'd2;
                15:          f3 = 3'd3;
                default:     f3 = 3'd0;
            endcase
            if (imm_form && op >= 5 && op <= 10) begin
                imm12 = word ? {1'b0, alt, 5'b0, r[10:6]} : {1'b0, alt, 4'b0, r[11:6]};
            end
            if (word) begin
                opc = imm_form ? 7'b0011011 : 7'b0111011;
            end else begin
                opc = imm_form ? 7'b0010011 : 7'b0110011;
            end
            if (imm_form) begin
                inst = {imm12, r[47:43], f3, rd, opc};
                opb = {{52{imm12[11]}}, imm12};
            end else begin
                inst = {1'b0, alt, 5'b0, r[52:48], r[47:43], f3, rd, opc};
                opb = s1;
            end
            sh = opb[5:0];
            case (op)
                1:  res = s0 + opb;
                2:  res = s0 - opb;
                3:  res = sext32(s0[31:0] + opb[31:0]);
                4:  res = sext32(s0[31:0] - opb[31:0]);
                5:  res = s0 << sh;
                6:  res = s0 >> sh;
                7:  res = $signed(s0) >>> sh;
                8:  res = sext32(s0[31:0] << sh[4:0]);
                9:  res = sext32(s0[31:0] >> sh[4:0]);
                10: res = sext32($signed(s0[31:0]) >>> sh[4:0]);
                11: res = s0 ^ opb;
                12: res = s0 | opb;
                13: res = s0 & opb;
                14: res = {63'd0, $signed(s0) < $signed(opb)};
                default: res = {63'd0, s0 < opb};
            endcase
        end else if (op == 16) begin
            imm_form = 1'b0;
            imm21 = {r[63:44], 1'b0};
            inst = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, 7'b1101111};
            tgt = pc + {{43{imm21[20]}}, imm21};
            taken = 1'b1;
            res = pc + 64'd4;
        end else if (op == 17) begin
            imm_form = 1'b0;
            inst = {imm12, r[47:43], 3'b000, rd, 7'b1100111};
            tgt = (s0 + {{52{imm12[11]}}, imm12}) & ~64'd1;
            taken = 1'b1;
            res = pc + 64'd4;
        end else begin
            imm_form = 1'b0;
            case (op)
                18:      f3 = 3'd0;
                19:      f3 = 3'd1;
                20:      f3 = 3'd4;
                21:      f3 = 3'd5;
                22:      f3 = 3'd6;
                default: f3 = 3'd7;
            endcase
            imm13 = {r[63:52], 1'b0};
            inst = {imm13[12], imm13[10:5], r[52:48], r[47:43], f3, imm13[4:1],
                    imm13[11], 7'b1100011};
            tgt = pc + {{51{imm13[12]}}, imm13};
            case (op)
                18:      taken = (s0 == s1);
                19:      taken = (s0 != s1);
                20:      taken = $signed(s0) < $signed(s1);
                21:      taken = !($signed(s0) < $signed(s1));
                22:      taken = s0 < s1;
                default: taken = !(s0 < s1);
            endcase
        end
        npc = taken ? tgt : pc + 64'd4;
        stim_state = xorshift(stim_state);
        // right about half the time
        pred = stim_state[0] ? npc : (taken ? pc + 64'd4 : tgt);
        if (op == 17) begin
            bt = (prd == 7'd1) ? br_call : ((prd == 7'd0) ? br_ret : br_indirect);
        end else if (op == 16) begin
            bt = br_direct;
        end else begin
            bt = br_cond;
        end
        fto = int'(r[33:29]) + 4;
        if (fto > `FTB_PREDICT_WIDTH - 1) begin
            fto = `FTB_PREDICT_WIDTH - 1;
        end
        d = '0;
        d.inst = inst;
        d.pc = pc;
        d.pred_npc = pred;
        d.srcs[0] = s0;
        d.srcs[1] = s1;
        d.rob_idx = r[24:19];
        d.ftq_idx = r[28:25];
        d.ftq_offset = r[33:29];
        d.prd_idx = prd;
        c = '{rob_idx: r[24:19], prd_idx: prd, rd_wen: (rd != 5'd0) && (op < 18),
              use_imm: imm_form, result: res};
        b = '{branch_type: bt, rob_idx: r[24:19], ftq_idx: r[28:25], has_mispred: 1'b1,
              branch_taken: taken, fallthru_offset: fto[4:0], target_pc: tgt,
              branch_npc: npc};
        br_push = (op >= 16) && (npc != pred);
    endtask

    // holds the op until o_disp_rdy, returns on the accepting edge
    task automatic send_op();
        disp_info_t     d;
        comwb_info_t    c;
        branchwb_info_t b;
        logic           bp;
        make_op(d, c, b, bp);
        @(negedge clk);
        i_disp_vld = 1'b1;
        i_disp_info = d;
        while (!o_disp_rdy) begin
            @(negedge clk);
        end
        exp_com.push_back(c);
        if (c.rd_wen) begin
            exp_ww.push_back(c);
        end
        if (bp) begin
            exp_br.push_back(b);
        end
        @(posedge clk);
    endtask

    // ready randomization and output checks
    initial begin
        comwb_info_t    ce;
        branchwb_info_t be;
        i_comwb_rdy = 1'b1;
        i_brwb_rdy = 1'b1;
        rdy_state = 64'd41567 ^ 64'h5a5a;
        forever begin
            @(negedge clk);
            if (rand_ready) begin
                rdy_state = xorshift(rdy_state);
                i_comwb_rdy = (rdy_state[2:0] > 3'd3);
                i_brwb_rdy = (rdy_state[5:3] > 3'd2);
            end
            if (!rst) begin
                if (o_comwb_vld && i_comwb_rdy) begin
                    if (exp_com.size() == 0) begin
                        stop_run("unexpected record on the common writeback stream");
                    end
                    ce = exp_com.pop_front();
                    check_value("o_comwb_info", o_comwb_info, ce);
                end
                if (o_brwb_vld && i_brwb_rdy) begin
                    if (exp_br.size() == 0) begin
                        stop_run("unexpected record on the branch writeback stream");
                    end
                    be = exp_br.pop_front();
                    check_value("o_brwb_info", o_brwb_info, be);
                end
                // stall low means the bypass entry moves on at the next edge
                if (o_willwrite_vld && o_disp_rdy) begin
                    if (exp_ww.size() == 0) begin
                        stop_run("bypass pulse with no writing op in flight");
                    end
                    ce = exp_ww.pop_front();
                    check_value("o_willwrite_idx", o_willwrite_idx, ce.prd_idx);
                    check_value("o_willwrite_data", o_willwrite_data, ce.result);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before every record came out");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        int cycles;
        rst = 1'b1;
        i_disp_vld = 1'b0;
        i_disp_info = '0;
        rand_ready = 1'b0;
        stim_state = 64'd41567;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_disp_rdy", o_disp_rdy, 1'b1);
        check_value("o_comwb_vld", o_comwb_vld, 1'b0);

        // single op after idle with both readies high
        send_op();
        @(negedge clk);
        i_disp_vld = 1'b0;
        cycles = 1;
        while (!o_comwb_vld && cycles < 20) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        check_value("comwb latency", cycles, 4);
        repeat (4) @(negedge clk);

        rand_ready = 1'b1;
        for (int i = 1; i < N_OPS; i++) begin
            stim_state = xorshift(stim_state);
            if (stim_state[1:0] == 2'b00) begin
                @(negedge clk);
                i_disp_vld = 1'b0;
            end
            send_op();
        end
        @(negedge clk);
        i_disp_vld = 1'b0;
        while (exp_com.size() != 0 || exp_br.size() != 0 || exp_ww.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        check_value("o_comwb_vld", o_comwb_vld, 1'b0);
        check_value("o_brwb_vld", o_brwb_vld, 1'b0);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/exu_pkg.sv
hdl/uop_decode.sv
hdl/alu_bru.sv
hdl/wb_queue.sv
hdl/exu_top.sv
sim/tb_exu.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_exu -o tb_exu

./obj_dir/tb_exu | tee sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
